// ==== verification/cluster_patterns.txt ====
// Columns: test index, src, count, dst, expected sums of sockets 0 to 3, all hex
// Word at address a holds a * 3 + 0x1000
00000000 00000100 00000004 00000800 00004c12 00004c42 00004c72 00004ca2
00000001 00000200 00000000 00000900 00000000 00000000 00000000 00000000
00000002 00000010 00000001 00000810 00001030 00001033 00001036 00001039
00000003 00000000 00000008 00000a00 00008054 00008114 000081d4 00008294
00000004 00000040 00000005 00000900 000053de 00005429 00005474 000054bf
00000005 00001000 00000002 00000000 00008003 0000800f 0000801b 00008027
00000006 00000020 00000003 000007fc 00003129 00003144 0000315f 0000317a
00000007 60000000 00000002 00000c00 40002003 4000200f 4000201b 40002027
00000008 00000300 00000006 00000b00 0000962d 00009699 00009705 00009771
00000009 fffffffc 00000001 00000c00 00000ff4 00000ff7 00000ffa 00000ffd
0000000a 00000000 00000007 00000d00 0000703f 000070d2 00007165 000071f8
0000000b 00000100 00000004 00000800 00004c12 00004c42 00004c72 00004ca2

// ==== project.f ====
+incdir+include
design/cluster_pkg.sv
design/cluster_ctrl.sv
design/socket.sv
design/mem_arb.sv
design/cluster.sv
verification/cluster_checker.sv
verification/cluster_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module cluster_tb -f project.f
	@out=$$(./obj_dir/Vcluster_tb); echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed!"

clean:
	rm -rf obj_dir

// ==== verification/cluster_tb.sv ====
// Cluster testbench

`timescale 1ns/1ps

`include "cluster_defs.svh"

module cluster_tb import cluster_pkg::*; ();

    localparam int NUM_TESTS      = 12;
    localparam int FIELDS         = 4 + `NUM_SOCKETS;
    localparam int TIMEOUT_CYCLES = 200 * NUM_TESTS;

    logic      clk;
    logic      reset           = 1'b1;
    logic      dcr_write_valid = 1'b0;
    dcr_addr_t dcr_write_addr  = '0;
    word_t     dcr_write_data  = '0;
    logic      mem_req_valid;
    logic      mem_req_rw;
    addr_t     mem_req_addr;
    word_t     mem_req_data;
    mem_tag_t  mem_req_tag;
    logic      mem_req_ready   = 1'b0;
    logic      mem_rsp_valid   = 1'b0;
    word_t     mem_rsp_data    = '0;
    mem_tag_t  mem_rsp_tag     = '0;
    logic      busy;

    // Test context shared with the checker
    logic  test_active = 1'b0;
    logic  test_end    = 1'b0;
    logic  run_end     = 1'b0;
    word_t test_id     = '0;
    addr_t test_dst    = '0;
    word_t exp_sum [`NUM_SOCKETS] = '{default: '0};
    int    error_count;
    int    cycle = 0;
    logic  load_ok;
    word_t pat_mem [NUM_TESTS * FIELDS];

    // Reads in flight inside the memory model
    int       rsp_due [$];
    word_t    rsp_word [$];
    mem_tag_t rsp_tag [$];

    cluster UUT (.*);

    cluster_checker result_check (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    // Word at address a holds a * 3 + 0x1000 and reads return in order
    always @(posedge clk) begin
        if (reset) begin
            mem_req_ready <= 1'b0;
            mem_rsp_valid <= 1'b0;
        end else begin
            mem_req_ready <= ($urandom % 4) != 0;
            if (mem_req_valid && mem_req_ready && !mem_req_rw) begin
                rsp_due.push_back(cycle + 1 + int'($urandom % 6));
                rsp_word.push_back(mem_req_addr * 3 + 32'h1000);
                rsp_tag.push_back(mem_req_tag);
            end
            mem_rsp_valid <= 1'b0;
            if (rsp_due.size() > 0 && rsp_due[0] <= cycle) begin
                mem_rsp_valid <= 1'b1;
                mem_rsp_data  <= rsp_word.pop_front();
                mem_rsp_tag   <= rsp_tag.pop_front();
                rsp_due.delete(0);
            end
        end
    end

    task automatic dcr_write(input dcr_addr_t addr, input word_t data);
        @(posedge clk);
        dcr_write_valid <= 1'b1;
        dcr_write_addr  <= addr;
        dcr_write_data  <= data;
        @(posedge clk);
        dcr_write_valid <= 1'b0;
    endtask

    task automatic run_test(input int t);
        int base;
        base = t * FIELDS;
        @(posedge clk);
        test_id     <= pat_mem[base];
        test_dst    <= pat_mem[base + 3];
        test_active <= 1'b1;
        for (int k = 0; k < `NUM_SOCKETS; k++) begin
            exp_sum[k] <= pat_mem[base + 4 + k];
        end
        dcr_write(`DCR_SRC_ADDR, pat_mem[base + 1]);
        dcr_write(`DCR_COUNT, pat_mem[base + 2]);
        dcr_write(`DCR_DST_ADDR, pat_mem[base + 3]);
        dcr_write(`DCR_START, '0);
        do @(posedge clk); while (!busy);
        do @(posedge clk); while (busy);
        test_end    <= 1'b1;
        test_active <= 1'b0;
        @(posedge clk);
        test_end <= 1'b0;
        // Stray writes outside the base range
        dcr_write(12'h000, word_t'($urandom));
        dcr_write(12'h005, word_t'($urandom));
    endtask

    initial begin
        void'($urandom(32'h58db_c895));
        $readmemh("verification/cluster_patterns.txt", pat_mem);
        load_ok = (pat_mem[(NUM_TESTS - 1) * FIELDS] == word_t'(NUM_TESTS - 1));
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        if (!load_ok) begin
            $display("Pattern file is missing or has too few lines");
        end else begin
            for (int t = 0; t < NUM_TESTS; t++) begin
                run_test(t);
            end
        end
        run_end <= 1'b1;
        @(posedge clk);
        run_end <= 1'b0;
        @(posedge clk);
        if (load_ok && error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== verification/cluster_checker.sv ====
// Cluster result checker

`timescale 1ns/1ps

`include "cluster_defs.svh"

module cluster_checker import cluster_pkg::*; (
    input  wire      clk,
    input  wire      reset,

    // Memory request port of the DUT
    input  wire      mem_req_valid,
    input  wire      mem_req_ready,
    input  wire      mem_req_rw,
    input  addr_t    mem_req_addr,
    input  word_t    mem_req_data,
    input  mem_tag_t mem_req_tag,
    input  wire      busy,

    // Test context from the stimulus side
    input  wire      test_active,
    input  wire      test_end,
    input  wire      run_end,
    input  word_t    test_id,
    input  addr_t    test_dst,
    input  word_t    exp_sum [`NUM_SOCKETS],
    output int       error_count
);

    int                      errors       = 0;
    int                      test_errors  = 0;
    int                      tests_passed = 0;
    int                      tests_failed = 0;
    int                      write_cnt    = 0;
    logic [`NUM_SOCKETS-1:0] seen         = '0;
    logic                    busy_q       = 1'b0;
    logic                    busy_seen    = 1'b0;
    string                   name;

    assign error_count = errors;

    task automatic flag(input string msg);
        $display("%s", msg);
        test_errors++;
        errors++;
    endtask

    always @(posedge clk) begin
        addr_t     offset;
        sock_idx_t idx;
        name = $sformatf("test_%0d", test_id);
        if (reset) begin
            busy_q = 1'b0;
        end else begin
            if (!test_active && (busy || mem_req_valid))
                flag($sformatf("ERROR %s: busy or a memory request while no job runs", name));
            // Busy may only fall once every socket has written its sum
            if (busy_q && !busy && test_active && write_cnt != `NUM_SOCKETS)
                flag($sformatf("ERROR %s: busy fell after only %0d result writes",
                               name, write_cnt));
            busy_seen = busy_seen || busy;
            if (mem_req_valid && mem_req_ready && mem_req_rw) begin
                offset = mem_req_addr - test_dst;
                idx    = sock_idx_t'(offset);
                write_cnt++;
                if (offset >= addr_t'(`NUM_SOCKETS)) begin
                    flag($sformatf("ERROR %s: result written to unexpected address 0x%08h",
                                   name, mem_req_addr));
                end else if (seen[idx]) begin
                    flag($sformatf("ERROR %s: socket %0d wrote its result twice", name, idx));
                end else begin
                    seen[idx] = 1'b1;
                    if (mem_req_tag != mem_tag_t'(idx))
                        flag($sformatf("ERROR %s: socket %0d result carried tag %0d",
                                       name, idx, mem_req_tag));
                    if (mem_req_data != exp_sum[idx])
                        flag($sformatf("CHECK FAILED %s socket %0d: expected 0x%08h, actual 0x%08h",
                                       name, idx, exp_sum[idx], mem_req_data));
                end
            end
            if (test_end) begin
                if (!busy_seen)
                    flag($sformatf("ERROR %s: busy never went high", name));
                for (int k = 0; k < `NUM_SOCKETS; k++) begin
                    if (!seen[k])
                        flag($sformatf("ERROR %s: no result write from socket %0d", name, k));
                end
                $display("%s: %s, %0d result writes, %0d errors", name,
                         (test_errors == 0) ? "pass" : "FAIL", write_cnt, test_errors);
                if (test_errors == 0) tests_passed++;
                else tests_failed++;
                test_errors = 0;
                write_cnt   = 0;
                seen        = '0;
                busy_seen   = 1'b0;
            end
            busy_q = busy;
        end
        if (run_end)
            $display("Totals: %0d tests passed, %0d tests failed, %0d errors",
                     tests_passed, tests_failed, errors);
    end

endmodule

// ==== design/cluster.sv ====
// Compute cluster top level

`timescale 1ns/1ps

`include "cluster_defs.svh"

module cluster import cluster_pkg::*; (
    input  wire       clk,
    input  wire       reset,

    // DCR writes
    input  wire       dcr_write_valid,
    input  dcr_addr_t dcr_write_addr,
    input  word_t     dcr_write_data,

    // Memory request
    output logic      mem_req_valid,
    output logic      mem_req_rw,
    output addr_t     mem_req_addr,
    output word_t     mem_req_data,
    output mem_tag_t  mem_req_tag,
    input  wire       mem_req_ready,

    // Memory response
    input  wire       mem_rsp_valid,
    input  word_t     mem_rsp_data,
    input  mem_tag_t  mem_rsp_tag,

    // Status
    output logic      busy
);

    logic                    sock_dcr_valid;
    dcr_addr_t               sock_dcr_addr;
    word_t                   sock_dcr_data;
    logic [`NUM_SOCKETS-1:0] sock_busy;

    logic [`NUM_SOCKETS-1:0] req_valid;
    logic [`NUM_SOCKETS-1:0] req_rw;
    addr_t                   req_addr [`NUM_SOCKETS];
    word_t                   req_data [`NUM_SOCKETS];
    logic [`NUM_SOCKETS-1:0] req_ready;
    logic [`NUM_SOCKETS-1:0] rsp_valid;
    word_t                   rsp_data;

    cluster_ctrl ctrl (
        .clk             (clk),
        .reset           (reset),
        .dcr_write_valid (dcr_write_valid),
        .dcr_write_addr  (dcr_write_addr),
        .dcr_write_data  (dcr_write_data),
        .sock_dcr_valid  (sock_dcr_valid),
        .sock_dcr_addr   (sock_dcr_addr),
        .sock_dcr_data   (sock_dcr_data),
        .sock_busy       (sock_busy),
        .busy            (busy)
    );

    // One summing engine per socket index
    for (genvar i = 0; i < `NUM_SOCKETS; i++) begin : g_sockets
        socket #(
            .SOCKET_ID (i)
        ) sock (
            .clk       (clk),
            .reset     (reset),
            .dcr_valid (sock_dcr_valid),
            .dcr_addr  (sock_dcr_addr),
            .dcr_data  (sock_dcr_data),
            .req_valid (req_valid[i]),
            .req_rw    (req_rw[i]),
            .req_addr  (req_addr[i]),
            .req_data  (req_data[i]),
            .req_ready (req_ready[i]),
            .rsp_valid (rsp_valid[i]),
            .rsp_data  (rsp_data),
            .busy      (sock_busy[i])
        );
    end

    mem_arb arb (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req_rw        (req_rw),
        .req_addr      (req_addr),
        .req_data      (req_data),
        .req_ready     (req_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req_rw    (mem_req_rw),
        .mem_req_addr  (mem_req_addr),
        .mem_req_data  (mem_req_data),
        .mem_req_tag   (mem_req_tag),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .mem_rsp_tag   (mem_rsp_tag),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data)
    );

endmodule

// ==== design/mem_arb.sv ====
// Round-robin memory request arbiter

`timescale 1ns/1ps

`include "cluster_defs.svh"

module mem_arb import cluster_pkg::*; (
    input  wire                    clk,
    input  wire                    reset,

    // Per-socket requests
    input  wire [`NUM_SOCKETS-1:0] req_valid,
    input  wire [`NUM_SOCKETS-1:0] req_rw,
    input  addr_t                  req_addr [`NUM_SOCKETS],
    input  word_t                  req_data [`NUM_SOCKETS],
    output logic [`NUM_SOCKETS-1:0] req_ready,

    // Shared memory request port
    output logic                   mem_req_valid,
    output logic                   mem_req_rw,
    output addr_t                  mem_req_addr,
    output word_t                  mem_req_data,
    output mem_tag_t               mem_req_tag,
    input  wire                    mem_req_ready,

    // Shared memory response port
    input  wire                    mem_rsp_valid,
    input  word_t                  mem_rsp_data,
    input  mem_tag_t               mem_rsp_tag,

    // Routed responses
    output logic [`NUM_SOCKETS-1:0] rsp_valid,
    output word_t                  rsp_data
);

    sock_idx_t last_q;
    sock_idx_t grant_idx;
    logic      grant_found;
    logic      locked_q;
    sock_idx_t locked_idx_q;

    // Search starts at the socket after the last one served
    always_comb begin
        sock_idx_t cand;
        grant_found = 1'b0;
        grant_idx   = last_q;
        cand        = last_q;
        for (int i = 1; i <= `NUM_SOCKETS; i++) begin
            cand = sock_idx_t'((int'(last_q) + i) % `NUM_SOCKETS);
            if (!grant_found && req_valid[cand]) begin
                grant_found = 1'b1;
                grant_idx   = cand;
            end
        end
        // A stalled request keeps the port until it transfers
        if (locked_q) begin
            grant_found = 1'b1;
            grant_idx   = locked_idx_q;
        end
    end

    assign mem_req_valid = grant_found;
    assign mem_req_rw    = req_rw[grant_idx];
    assign mem_req_addr  = req_addr[grant_idx];
    assign mem_req_data  = req_data[grant_idx];
    assign mem_req_tag   = mem_tag_t'(grant_idx);

    always_comb begin
        for (int i = 0; i < `NUM_SOCKETS; i++) begin
            req_ready[i] = grant_found && mem_req_ready && (grant_idx == sock_idx_t'(i));
            rsp_valid[i] = mem_rsp_valid && (mem_rsp_tag == mem_tag_t'(i));
        end
    end

    assign rsp_data = mem_rsp_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            // Socket 0 goes first after reset
            last_q   <= sock_idx_t'(`NUM_SOCKETS - 1);
            locked_q <= 1'b0;
        end else begin
            if (mem_req_valid && mem_req_ready) begin
                last_q <= grant_idx;
            end
            locked_q <= mem_req_valid && !mem_req_ready;
        end
    end

    always_ff @(posedge clk) begin
        locked_idx_q <= grant_idx;
    end

endmodule

// ==== design/socket.sv ====
// Summing socket engine

`timescale 1ns/1ps

`include "cluster_defs.svh"

module socket import cluster_pkg::*; #(
    parameter int SOCKET_ID = 0
) (
    input  wire        clk,
    input  wire        reset,

    // Configuration writes
    input  wire        dcr_valid,
    input  dcr_addr_t  dcr_addr,
    input  word_t      dcr_data,

    // Memory request
    output logic       req_valid,
    output logic       req_rw,
    output addr_t      req_addr,
    output word_t      req_data,
    input  wire        req_ready,

    // Read response
    input  wire        rsp_valid,
    input  word_t      rsp_data,

    output logic       busy
);

    localparam int OUT_WIDTH = $clog2(`MAX_OUTSTANDING + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE
    } state_t;

    state_t               state;
    addr_t                src_q;
    word_t                count_q;
    addr_t                dst_q;
    addr_t                rd_addr;
    word_t                rd_left;
    word_t                rsp_left;
    word_t                acc;
    logic [OUT_WIDTH-1:0] outstanding;
    logic                 start;
    logic                 rd_fire;

    assign start = dcr_valid && (dcr_addr == `DCR_START) && (state == ST_IDLE);

    // Read issue stops when all reads are out or the window is full
    assign req_valid = ((state == ST_READ) && (rd_left != '0)
                        && (outstanding < OUT_WIDTH'(`MAX_OUTSTANDING)))
                    || (state == ST_WRITE);
    assign req_rw    = (state == ST_WRITE);
    assign req_addr  = (state == ST_WRITE) ? (dst_q + addr_t'(SOCKET_ID)) : rd_addr;
    assign req_data  = acc;
    assign rd_fire   = req_valid && req_ready && (state == ST_READ);
    assign busy      = (state != ST_IDLE);

    // Base state also updates while running
    always_ff @(posedge clk) begin
        if (dcr_valid) begin
            case (dcr_addr)
                `DCR_SRC_ADDR: src_q   <= dcr_data;
                `DCR_COUNT:    count_q <= dcr_data;
                `DCR_DST_ADDR: dst_q   <= dcr_data;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= ST_IDLE;
            outstanding <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        // Block for this socket starts at src + id * count
                        rd_addr     <= src_q + addr_t'(SOCKET_ID) * count_q;
                        rd_left     <= count_q;
                        rsp_left    <= count_q;
                        acc         <= '0;
                        outstanding <= '0;
                        state       <= (count_q == '0) ? ST_WRITE : ST_READ;
                    end
                end
                ST_READ: begin
                    if (rd_fire) begin
                        rd_addr <= rd_addr + addr_t'(1);
                        rd_left <= rd_left - word_t'(1);
                    end
                    case ({rd_fire, rsp_valid})
                        2'b10:   outstanding <= outstanding + OUT_WIDTH'(1);
                        2'b01:   outstanding <= outstanding - OUT_WIDTH'(1);
                        default: ;
                    endcase
                    if (rsp_valid) begin
                        acc      <= acc + rsp_data;
                        rsp_left <= rsp_left - word_t'(1);
                        if (rsp_left == word_t'(1)) begin
                            state <= ST_WRITE;
                        end
                    end
                end
                ST_WRITE: begin
                    // Sum leaves with this request
                    if (req_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== design/cluster_ctrl.sv ====
// Cluster DCR relay and busy aggregation

`timescale 1ns/1ps

`include "cluster_defs.svh"

module cluster_ctrl import cluster_pkg::*; (
    input  wire                    clk,
    input  wire                    reset,

    // DCR write strobe from outside
    input  wire                    dcr_write_valid,
    input  dcr_addr_t              dcr_write_addr,
    input  word_t                  dcr_write_data,

    // Registered copy shared by all sockets
    output logic                   sock_dcr_valid,
    output dcr_addr_t              sock_dcr_addr,
    output word_t                  sock_dcr_data,

    // Status
    input  wire [`NUM_SOCKETS-1:0] sock_busy,
    output logic                   busy
);

    logic is_base_addr;
    logic is_start_addr;
    logic pass_write;

    // Only base-state writes and the start command reach the sockets
    assign is_base_addr  = (dcr_write_addr >= `DCR_BASE_BEGIN)
                        && (dcr_write_addr < `DCR_BASE_END);
    assign is_start_addr = (dcr_write_addr == `DCR_START);
    assign pass_write    = dcr_write_valid && (is_base_addr || is_start_addr);

    always_ff @(posedge clk) begin
        if (reset) begin
            sock_dcr_valid <= 1'b0;
            busy           <= 1'b0;
        end else begin
            sock_dcr_valid <= pass_write;
            busy           <= |sock_busy;
        end
    end

    // Payload only moves when a write is passed on
    always_ff @(posedge clk) begin
        if (pass_write) begin
            sock_dcr_addr <= dcr_write_addr;
            sock_dcr_data <= dcr_write_data;
        end
    end

endmodule

// ==== design/cluster_pkg.sv ====
// Cluster shared types

`include "cluster_defs.svh"

package cluster_pkg;

    // One data word on the memory port
    typedef logic [`WORD_WIDTH-1:0] word_t;

    // Word address
    typedef logic [`ADDR_WIDTH-1:0] addr_t;

    // Configuration register address
    typedef logic [`DCR_ADDR_WIDTH-1:0] dcr_addr_t;

    // Socket index is at least one bit wide
    localparam int SOCK_IDX_WIDTH = (`NUM_SOCKETS > 1) ? $clog2(`NUM_SOCKETS) : 1;

    typedef logic [SOCK_IDX_WIDTH-1:0] sock_idx_t;

    // Memory tag carries the socket index of the requester
    typedef logic [SOCK_IDX_WIDTH-1:0] mem_tag_t;

endpackage

// ==== include/cluster_defs.svh ====
// Cluster configuration macros

`ifndef CLUSTER_DEFS_SVH
`define CLUSTER_DEFS_SVH

// Number of summing sockets in the cluster
`define NUM_SOCKETS 4

// Datapath widths
`define WORD_WIDTH 32
`define ADDR_WIDTH 32
`define DCR_ADDR_WIDTH 12

// Base-state DCR window with an exclusive end
`define DCR_BASE_BEGIN 12'h001
`define DCR_BASE_END 12'h004

// Base-state registers
`define DCR_SRC_ADDR 12'h001
`define DCR_COUNT 12'h002
`define DCR_DST_ADDR 12'h003

// Kicks off all sockets
`define DCR_START 12'h004

// Reads one socket may keep in flight
`define MAX_OUTSTANDING 4

`endif
